// ==== hdl/vga_row_pkg.sv ====
package vga_row_pkg;

	// Frame selector, memory and pixel types
	typedef logic [2:0]   frame_sel_t;       // Values 0 to 5 valid
	typedef logic [24:0]  mem_addr_t;        // Memory word address
	typedef logic [127:0] beat_t;            // One memory beat
	typedef logic [15:0]  pixel_t;           // One RGB565 pixel

	typedef struct packed {
		logic      req;                      // Read request pulse
		mem_addr_t addr;                     // Valid while req high
	} rd_req_t;

	typedef struct packed {
		logic  valid;                        // Data pulse
		beat_t data;
	} rd_resp_t;

	parameter int NUM_FRAMES      = 6;
	parameter int ADDR_STEP       = 4;       // Word address advance per beat
	parameter int PIXELS_PER_BEAT = 8;

	// Base address per selector, selector 5 sits at the bottom of memory
	parameter mem_addr_t FRAME_BASE [NUM_FRAMES] = '{
		25'h25800, 25'h4B000, 25'h70800, 25'h96000, 25'hBB800, 25'h0
	};

	// Out-of-range selectors fall back to address zero
	function automatic mem_addr_t frame_base(frame_sel_t sel);
		if (sel < frame_sel_t'(NUM_FRAMES))
			return FRAME_BASE[sel];
		return '0;
	endfunction

endpackage

// ==== hdl/row_fetch_fsm.sv ====
`timescale 1ns/1ps

module row_fetch_fsm (
	input  logic clk_133M,
	input  logic rst_n_133M,
	input  logic start_row,
	input  logic rd_valid,
	input  logic ram_busy,
	input  logic last_beat,
	output logic req
);

	typedef enum logic [2:0] {
		IDLE,
		ARM,        // First trigger of a row
		ISSUE,      // Request pending behind ram_busy
		WAIT_DATA,  // One beat outstanding
		DONE
	} state_t;

	state_t state;
	logic   trigger;
	logic   row_end;

	// A request may go out one cycle after any of these
	assign trigger = (state == ARM) ||
			(state == ISSUE) ||
			(state == WAIT_DATA && rd_valid && !last_beat);

	assign row_end = (state == WAIT_DATA) && rd_valid && last_beat;

	always_ff @(posedge clk_133M) begin
		if (!rst_n_133M) begin
			state <= IDLE;
			req   <= 1'b0;
		end else begin
			req <= 1'b0;                  // Single-cycle pulse
			if (start_row) begin
				state <= ARM;             // Restart from any state
			end else if (trigger) begin
				if (!ram_busy) begin
					req   <= 1'b1;
					state <= WAIT_DATA;
				end else begin
					state <= ISSUE;       // Retry next cycle
				end
			end else if (row_end) begin
				state <= DONE;
			end
		end
	end

	// IDLE and DONE only leave on start_row, which the branch above covers.
	// A response that arrives outside WAIT_DATA belongs to an aborted row
	// and does not trigger a new request.

endmodule

// ==== hdl/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter #(
	parameter int ROW_BEATS = 80
) (
	input  logic                         clk_133M,
	input  logic                         rst_n_133M,
	input  logic                         start_row,
	input  logic                         rd_valid,
	output logic [$clog2(ROW_BEATS)-1:0] wr_addr,
	output logic                         wr_en,
	output logic                         last_beat
);

	localparam int BEAT_W = $clog2(ROW_BEATS);
	localparam int CNT_W  = $clog2(ROW_BEATS + 1);  // Must hold ROW_BEATS

	logic [CNT_W-1:0] count;
	logic             in_range;

	assign in_range = (count < CNT_W'(ROW_BEATS));

	always_ff @(posedge clk_133M) begin
		if (!rst_n_133M) begin
			count <= CNT_W'(ROW_BEATS);     // Idle as a finished row
		end else if (start_row) begin
			count <= '0;
		end else if (rd_valid && in_range) begin
			count <= count + 1'b1;          // Saturates at ROW_BEATS
		end
	end

	assign wr_addr   = count[BEAT_W-1:0];
	assign wr_en     = rd_valid && in_range;      // No writes past the row
	assign last_beat = rd_valid && (count == CNT_W'(ROW_BEATS - 1));

endmodule

// ==== hdl/read_addr_gen.sv ====
`timescale 1ns/1ps

module read_addr_gen
	import vga_row_pkg::*;
(
	input  logic       clk_133M,
	input  logic       rst_n_133M,
	input  logic       start_frame,
	input  frame_sel_t last_frame,
	input  logic       req,
	output rd_req_t    rd
);

	mem_addr_t addr;

	// The address runs on across the rows of a frame and is only
	// reloaded at the start of the next frame
	always_ff @(posedge clk_133M) begin
		if (!rst_n_133M) begin
			addr <= '0;
		end else if (start_frame) begin
			addr <= frame_base(last_frame);       // Selected frame base
		end else if (req) begin
			addr <= addr + mem_addr_t'(ADDR_STEP);  // Step after each request
		end
	end

	assign rd.req  = req;
	assign rd.addr = addr;                  // Holds while req is high

endmodule

// ==== hdl/row_ram.sv ====
`timescale 1ns/1ps

module row_ram
	import vga_row_pkg::*;
#(
	parameter int ROW_BEATS = 80
) (
	input  logic                                           clk_133M,
	input  logic                                           wr_en,
	input  logic [$clog2(ROW_BEATS)-1:0]                   wr_addr,
	input  beat_t                                          wr_data,
	input  logic                                           rd_en,
	input  logic [$clog2(ROW_BEATS*PIXELS_PER_BEAT)-1:0]   rd_addr,
	output pixel_t                                         pixel_data,
	output logic                                           pixel_valid
);

	localparam int LANE_W = $clog2(PIXELS_PER_BEAT);
	localparam int BEAT_W = $clog2(ROW_BEATS);
	localparam int PIX_W  = $clog2(ROW_BEATS * PIXELS_PER_BEAT);
	localparam int LANE_BITS = $bits(pixel_t);

	beat_t              mem [ROW_BEATS];   // One row of beats
	logic [BEAT_W-1:0]  rd_beat;
	logic [LANE_W-1:0]  rd_lane;
	pixel_t             lane_word;

	assign rd_beat   = rd_addr[PIX_W-1:LANE_W];
	assign rd_lane   = rd_addr[LANE_W-1:0];     // Lane 0 is the LSBs
	assign lane_word = mem[rd_beat][rd_lane*LANE_BITS +: LANE_BITS];

	always_ff @(posedge clk_133M) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Memory stores pixels little-endian, the display wants the high byte first
	always_ff @(posedge clk_133M) begin
		pixel_valid <= rd_en;
		if (rd_en)
			pixel_data <= {lane_word[7:0], lane_word[15:8]};  // Byte swap
	end

endmodule

// ==== hdl/pixel_scan.sv ====
`timescale 1ns/1ps

module pixel_scan
	import vga_row_pkg::*;
#(
	parameter int ROW_BEATS = 80,
	parameter int H_RESTART = 798
) (
	input  logic                                         clk_133M,
	input  logic                                         rst_n_133M,
	input  logic                                         pixel_tick,
	input  logic [9:0]                                   h_count,
	output logic [$clog2(ROW_BEATS*PIXELS_PER_BEAT)-1:0] rd_addr,
	output logic                                         rd_en
);

	localparam int NUM_PIX = ROW_BEATS * PIXELS_PER_BEAT;
	localparam int PIX_W   = $clog2(NUM_PIX);
	localparam int CNT_W   = $clog2(NUM_PIX + 1);  // Parks at NUM_PIX

	logic [CNT_W-1:0] pix_cnt;

	always_ff @(posedge clk_133M) begin
		if (!rst_n_133M) begin
			pix_cnt <= CNT_W'(NUM_PIX);         // No output until first restart
			rd_en   <= 1'b0;
		end else if (pixel_tick) begin
			if (h_count == 10'(H_RESTART)) begin
				pix_cnt <= '0;
				rd_en   <= 1'b1;
			end else begin
				if (pix_cnt < CNT_W'(NUM_PIX))
					pix_cnt <= pix_cnt + 1'b1;
				rd_en <= (pix_cnt < CNT_W'(NUM_PIX - 1));  // Drop after last pixel
			end
		end
	end

	assign rd_addr = pix_cnt[PIX_W-1:0];

endmodule

// ==== hdl/vga_row_fetch_top.sv ====
`timescale 1ns/1ps

module vga_row_fetch_top
	import vga_row_pkg::*;
#(
	parameter int ROW_BEATS = 80,
	parameter int H_RESTART = 798
) (
	input  logic       clk_133M,
	input  logic       rst_n_133M,
	input  logic       start_frame,
	input  logic       start_row,
	input  frame_sel_t last_frame,
	input  logic       ram_busy,
	input  rd_resp_t   rd_resp,
	input  logic [9:0] h_count,
	input  logic       pixel_tick,
	output rd_req_t    rd,
	output pixel_t     pixel_data,
	output logic       pixel_valid
);

	localparam int BEAT_W = $clog2(ROW_BEATS);
	localparam int PIX_W  = $clog2(ROW_BEATS * PIXELS_PER_BEAT);

	logic              req;
	logic              last_beat;
	logic              wr_en;
	logic [BEAT_W-1:0] wr_addr;
	logic              pix_rd_en;
	logic [PIX_W-1:0]  pix_addr;

	row_fetch_fsm u_fsm (
		.clk_133M   (clk_133M),
		.rst_n_133M (rst_n_133M),
		.start_row  (start_row),
		.rd_valid   (rd_resp.valid),
		.ram_busy   (ram_busy),
		.last_beat  (last_beat),
		.req        (req)
	);

	beat_counter #(.ROW_BEATS(ROW_BEATS)) u_beats (
		.clk_133M   (clk_133M),
		.rst_n_133M (rst_n_133M),
		.start_row  (start_row),
		.rd_valid   (rd_resp.valid),
		.wr_addr    (wr_addr),
		.wr_en      (wr_en),
		.last_beat  (last_beat)
	);

	read_addr_gen u_addr (
		.clk_133M    (clk_133M),
		.rst_n_133M  (rst_n_133M),
		.start_frame (start_frame),
		.last_frame  (last_frame),
		.req         (req),
		.rd          (rd)
	);

	row_ram #(.ROW_BEATS(ROW_BEATS)) u_ram (
		.clk_133M    (clk_133M),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (rd_resp.data),
		.rd_en       (pix_rd_en),
		.rd_addr     (pix_addr),
		.pixel_data  (pixel_data),
		.pixel_valid (pixel_valid)
	);

	pixel_scan #(.ROW_BEATS(ROW_BEATS), .H_RESTART(H_RESTART)) u_scan (
		.clk_133M   (clk_133M),
		.rst_n_133M (rst_n_133M),
		.pixel_tick (pixel_tick),
		.h_count    (h_count),
		.rd_addr    (pix_addr),
		.rd_en      (pix_rd_en)
	);

endmodule

// ==== tb/vga_row_fetch_props.sv ====
`timescale 1ns/1ps

module vga_row_fetch_props
	import vga_row_pkg::*;
(
	input logic     clk_133M,
	input logic     rst_n_133M,
	input rd_req_t  rd,
	input rd_resp_t rd_resp
);

	logic outstanding;  // A beat has been requested and not yet returned

	always_ff @(posedge clk_133M) begin
		if (!rst_n_133M)
			outstanding <= 1'b0;
		else if (rd.req)
			outstanding <= 1'b1;
		else if (rd_resp.valid)
			outstanding <= 1'b0;
	end

	req_single: assert property (@(posedge clk_133M) disable iff (!rst_n_133M)
		rd.req |=> !rd.req)
		else $error("rd.req high in two consecutive cycles");

	req_reset: assert property (@(posedge clk_133M) !rst_n_133M |=> !rd.req)
		else $error("rd.req high after reset");

	req_one_outstanding: assert property (@(posedge clk_133M) disable iff (!rst_n_133M)
		outstanding |-> !rd.req)
		else $error("request issued while a beat is outstanding");

endmodule

bind vga_row_fetch_top vga_row_fetch_props i_props (
	.clk_133M   (clk_133M),
	.rst_n_133M (rst_n_133M),
	.rd         (rd),
	.rd_resp    (rd_resp)
);

// ==== tb/tb_vga_row_fetch.sv ====
`timescale 1ns/1ps

module tb_vga_row_fetch
	import vga_row_pkg::*;
();

	localparam int ROW_BEATS  = 80;
	localparam int H_RESTART  = 798;
	localparam int NUM_PIX    = ROW_BEATS * PIXELS_PER_BEAT;
	localparam int SCAN_TICKS = NUM_PIX + 4;    // A few ticks past the last pixel
	localparam int TICK_GAP   = 5;
	localparam int ROWS       = 14;
	localparam int LIMIT_CYCLES = 2 * ROWS * (ROW_BEATS * 12 + SCAN_TICKS * TICK_GAP + 40);

	logic       clk_133M;
	logic       rst_n_133M;
	logic       start_frame;
	logic       start_row;
	frame_sel_t last_frame;
	logic       ram_busy;
	rd_resp_t   rd_resp;
	logic [9:0] h_count;
	logic       pixel_tick;
	rd_req_t    rd;
	pixel_t     pixel_data;
	logic       pixel_valid;

	mem_addr_t  exp_addr;        // Next address the DUT must request
	mem_addr_t  pend_addr;
	int         req_total;       // Requests since start_frame
	int         row_reqs;
	int         row_resps;
	int         row_beat0;       // Beats of the frame before this row
	int         delay_cnt;
	bit         pending;
	bit         force_busy;
	bit         first_req;
	frame_sel_t cur_sel;

	vga_row_fetch_top #(.ROW_BEATS(ROW_BEATS), .H_RESTART(H_RESTART)) i_dut (.*);

	initial begin
		clk_133M = 1'b0;
		forever #20 clk_133M = ~clk_133M;
	end

	task automatic fail_now();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_addr(string name, mem_addr_t exp, mem_addr_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_pixel(string name, pixel_t exp, pixel_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (exp != act) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			fail_now();
		end
	endtask

	// Lane contents mix the whole address with the lane number
	function automatic pixel_t lane_value(mem_addr_t addr, int lane);
		return {addr[24:16], 3'(lane), 4'h5} ^ addr[15:0];
	endfunction

	function automatic beat_t beat_value(mem_addr_t addr);
		beat_t b;
		for (int l = 0; l < PIXELS_PER_BEAT; l++)
			b[l*16 +: 16] = lane_value(addr, l);
		return b;
	endfunction

	function automatic pixel_t ref_pixel(frame_sel_t sel, int beat0, int p);
		mem_addr_t addr;
		pixel_t    lane;
		addr = FRAME_BASE[sel] + mem_addr_t'((beat0 + p / PIXELS_PER_BEAT) * ADDR_STEP);
		lane = lane_value(addr, p % PIXELS_PER_BEAT);
		return {lane[7:0], lane[15:8]};  // Display byte order
	endfunction

	task automatic step();
		@(posedge clk_133M);
		#2;
	endtask

	// Memory controller model, one beat outstanding at most
	initial begin : memory_model
		void'($urandom(32'hf11d7d78));
		forever begin
			step();
			rd_resp.valid = 1'b0;
			ram_busy = ($urandom % 4 == 0) || force_busy;
			if (rst_n_133M && rd.req) begin
				if (pending) begin
					$display("[ERROR] request issued while a beat is outstanding");
					fail_now();
				end
				check_addr(first_req ? "first_addr" : "row_addr", exp_addr, rd.addr);
				first_req = 1'b0;
				exp_addr  = exp_addr + mem_addr_t'(ADDR_STEP);
				row_reqs++;
				req_total++;
				pending   = 1'b1;
				pend_addr = rd.addr;
				delay_cnt = 2 + int'($urandom % 5);  // 2 to 6 cycles
			end else if (pending) begin
				delay_cnt--;
				if (delay_cnt == 0) begin
					rd_resp.valid = 1'b1;
					rd_resp.data  = beat_value(pend_addr);
					pending       = 1'b0;
					row_resps++;
				end
			end
		end
	end

	// Pixel compare, two cycles after each tick
	initial begin : pixel_compare
		logic [1:0] tick_hist;
		logic [9:0] h_hist [2];
		int         exp_idx;
		tick_hist = '0;
		exp_idx   = NUM_PIX;  // No line in progress after reset
		forever begin
			@(negedge clk_133M);
			if (tick_hist[1]) begin
				if (h_hist[1] == 10'(H_RESTART))
					exp_idx = 0;
				else if (exp_idx < NUM_PIX)
					exp_idx++;
				check_bit("pixel_valid", exp_idx < NUM_PIX, pixel_valid);
				if (exp_idx < NUM_PIX)
					check_pixel($sformatf("pixel_%0d", exp_idx),
						ref_pixel(cur_sel, row_beat0, exp_idx), pixel_data);
			end
			tick_hist = {tick_hist[0], pixel_tick && rst_n_133M};
			h_hist[1] = h_hist[0];
			h_hist[0] = h_count;
		end
	end

	task automatic begin_frame(int sel);
		last_frame  = frame_sel_t'(sel);
		cur_sel     = frame_sel_t'(sel);
		exp_addr    = FRAME_BASE[sel];
		first_req   = 1'b1;
		req_total   = 0;
		start_frame = 1'b1;
		step();
		start_frame = 1'b0;
		step();
	endtask

	task automatic begin_row();
		row_beat0 = req_total;
		row_reqs  = 0;
		row_resps = 0;
		start_row = 1'b1;
		force_busy = 1'b0;
		step();
		start_row = 1'b0;
	endtask

	task automatic finish_row();
		while (row_resps < ROW_BEATS)
			step();
		repeat (8) step();                 // Catch any extra request
		check_count("row_requests", ROW_BEATS, row_reqs);
	endtask

	task automatic scan_line();
		for (int k = 0; k < SCAN_TICKS; k++) begin
			h_count    = 10'((H_RESTART + k) % 800);
			pixel_tick = 1'b1;
			step();
			pixel_tick = 1'b0;
			repeat (TICK_GAP - 1) step();
		end
		repeat (4) step();
	endtask

	initial begin : watchdog
		repeat (LIMIT_CYCLES) @(posedge clk_133M);
		$display("[ERROR] timeout, the tests did not complete in time");
		fail_now();
	end

	initial begin : main
		start_frame = 1'b0;
		start_row   = 1'b0;
		last_frame  = '0;
		ram_busy    = 1'b0;
		rd_resp     = '0;
		h_count     = '0;
		pixel_tick  = 1'b0;
		force_busy  = 1'b0;
		pending     = 1'b0;
		first_req   = 1'b0;
		exp_addr    = '0;
		req_total   = 0;
		row_reqs    = 0;
		row_resps   = 0;
		row_beat0   = 0;
		cur_sel     = '0;
		rst_n_133M  = 1'b0;
		repeat (2) begin
			step();
			check_bit("reset_req", 1'b0, rd.req);
		end
		rst_n_133M = 1'b1;
		step();
		check_bit("reset_req", 1'b0, rd.req);
		check_bit("reset_pixel_valid", 1'b0, pixel_valid);

		for (int s = 0; s < NUM_FRAMES; s++) begin
			begin_frame(s);
			repeat (2) begin           // Consecutive rows of one frame
				begin_row();
				finish_row();
				scan_line();
			end
		end

		// Row restart while a fetch is in progress
		begin_frame(3);
		begin_row();
		while (row_resps < 30)
			step();
		force_busy = 1'b1;             // Hold off further requests
		repeat (10) step();
		while (pending)
			step();
		repeat (4) step();
		begin_row();
		finish_row();
		scan_line();

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== vga_row_fetch_top.f ====
hdl/vga_row_pkg.sv
hdl/row_fetch_fsm.sv
hdl/beat_counter.sv
hdl/read_addr_gen.sv
hdl/row_ram.sv
hdl/pixel_scan.sv
hdl/vga_row_fetch_top.sv
tb/vga_row_fetch_props.sv
tb/tb_vga_row_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the VGA row fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_vga_row_fetch \
	-f vga_row_fetch_top.f \
	-o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "PASS: all tests" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
